/* dv/fetch_clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock (100 ns) and reset held low for 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_clk_gen (
    output logic clk,
    output logic rstn
);

    // Free-running clock, 50 ns high and 50 ns low
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset drops at time zero and is released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/fetch_top_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for fetch_top that stops at the first error
// Table entries marked IF_PREFETCH must follow the previous entry in sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_top_tb;

    import fetch_pkg::*;

    localparam int          LOAD_LEN = 64;
    localparam int          N_REQ    = 18;
    localparam int          LIMIT    = LOAD_LEN + 4 * N_REQ + 20;
    localparam logic [31:0] SEED     = 32'h42d5;

    // Request table with the pc, the reason and the expected latency in cycles
    localparam logic [31:0] TBL_PC [N_REQ] = '{
        32'd0,   32'd4,   32'd6,   32'd10,  32'd14,  32'd16,
        32'd18,  32'd20,  32'd30,  32'd34,  32'd38,  32'd42,
        32'd46,  32'd256, 32'd254, 32'd300, 32'd62,  32'd66
    };
    localparam if_reason_e TBL_REASON [N_REQ] = '{
        IF_PREDICT,    IF_PREFETCH, IF_PREFETCH, IF_PREFETCH, IF_PREFETCH, IF_PREFETCH,
        IF_PREFETCH,   IF_PREDICT,  IF_PREDICT,  IF_PREFETCH, IF_PREFETCH, IF_MISPREDICT,
        IF_MISPREDICT, IF_PREDICT,  IF_PREDICT,  IF_MISPREDICT, IF_PREDICT, IF_PREFETCH
    };
    localparam int TBL_LAT [N_REQ] = '{
        1, 1, 1, 1, 1, 1,
        1, 1, 2, 1, 1, 1,
        2, 1, 2, 1, 2, 1
    };

    logic                       clk;
    logic                       rstn;
    logic                       load_valid;
    logic [ICACHE_IDX_BITS-1:0] load_addr;
    logic [31:0]                load_data;
    logic                       req_valid;
    logic [XLEN-1:0]            req_pc;
    if_reason_e                 req_reason;
    logic                       resp_valid;
    logic [31:0]                resp_instr;
    logic                       resp_exception;
    logic                       resp_exception_plus2;

    // Program image with one entry per store word
    logic [31:0] image [64];

    // Set just before the first fetch is driven
    logic req_started;

    fetch_clk_gen clk_gen_i (
        .clk  (clk),
        .rstn (rstn)
    );

    fetch_top fetch_top_i (
        .clk                  (clk),
        .rstn                 (rstn),
        .load_valid           (load_valid),
        .load_addr            (load_addr),
        .load_data            (load_data),
        .req_valid            (req_valid),
        .req_pc               (req_pc),
        .req_reason           (req_reason),
        .resp_valid           (resp_valid),
        .resp_instr           (resp_instr),
        .resp_exception       (resp_exception),
        .resp_exception_plus2 (resp_exception_plus2)
    );

    // Halfwords that start a 32-bit instruction
    // All others are compressed
    function automatic logic hw_is_32(input logic [6:0] h);
        case (h)
            7'd0, 7'd3, 7'd5, 7'd10, 7'd15, 7'd17, 7'd23, 7'd31, 7'd127: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [15:0] hw_at(input logic [6:0] h);
        logic [31:0] word;
        word = image[h[6:1]];
        return h[0] ? word[31:16] : word[15:0];
    endfunction

    // Byte addresses of 256 and above lie past the 64-word store
    function automatic logic in_range(input logic [31:0] pc);
        return pc[31:8] == 24'd0;
    endfunction

    // Reference model built from the halfword image
    task automatic expect_resp(
        input  logic [31:0] pc,
        output logic [31:0] instr,
        output logic        fault,
        output logic        plus2
    );
        logic [15:0] lo;
        logic [31:0] nxt;
        instr = 32'd0;
        fault = 1'b0;
        plus2 = 1'b0;
        nxt   = pc + 32'd2;
        if (!in_range(pc)) begin
            fault = 1'b1;
        end else begin
            lo = hw_at(pc[7:1]);
            if (lo[1:0] != 2'b11) begin
                instr = {16'h0000, lo};
            end else if (!in_range(nxt)) begin
                // Only a misaligned start can push its upper half into the next word
                fault = 1'b1;
                plus2 = 1'b1;
            end else begin
                instr = {hw_at(nxt[7:1]), lo};
            end
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // No response may show up before any fetch is issued
    always @(negedge clk) begin
        if (!req_started) begin
            assert (resp_valid === 1'b0)
            else fail_run("resp_valid was not low before the first fetch request");
        end
    end

    initial begin
        #(LIMIT * 100);
        fail_run("timeout: a fetch response never arrived");
    end

    initial begin
        int          cycles;
        logic [31:0] r;
        logic [1:0]  len_bits;
        logic [15:0] hwv;
        logic [31:0] exp_instr;
        logic        exp_fault;
        logic        exp_plus2;

        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = 32'd0;
        req_valid   = 1'b0;
        req_pc      = '0;
        req_reason  = IF_PREFETCH;
        req_started = 1'b0;

        void'($urandom(SEED));

        // Random payload with length bits picked by the halfword pattern
        for (int h = 0; h < 128; h++) begin
            r = $urandom;
            if (hw_is_32(h[6:0])) begin
                len_bits = 2'b11;
            end else if (r[17:16] == 2'b11) begin
                len_bits = 2'b10;
            end else begin
                len_bits = r[17:16];
            end
            hwv = {r[15:2], len_bits};
            if (h[0]) begin
                image[h[6:1]][31:16] = hwv;
            end else begin
                image[h[6:1]][15:0] = hwv;
            end
        end

        @(posedge rstn);

        for (int i = 0; i < LOAD_LEN; i++) begin
            @(negedge clk);
            load_valid = 1'b1;
            load_addr  = i[5:0];
            load_data  = image[i[5:0]];
        end
        @(negedge clk);
        load_valid = 1'b0;
        repeat (2) @(negedge clk);

        req_started = 1'b1;
        for (int i = 0; i < N_REQ; i++) begin
            expect_resp(TBL_PC[i], exp_instr, exp_fault, exp_plus2);
            req_valid  = 1'b1;
            req_pc     = TBL_PC[i];
            req_reason = TBL_REASON[i];
            cycles     = 0;
            // Count falling edges until the response strobe is seen
            do begin
                @(negedge clk);
                req_valid = 1'b0;
                cycles++;
            end while (resp_valid !== 1'b1 && cycles < 8);

            assert (resp_valid === 1'b1)
            else fail_run($sformatf("no response for pc %h within 8 cycles", TBL_PC[i]));
            assert (cycles == TBL_LAT[i])
            else fail_run($sformatf("mismatch at %0t: pc %h latency expected %0d got %0d",
                                    $time, TBL_PC[i], TBL_LAT[i], cycles));
            assert (resp_exception === exp_fault)
            else fail_run($sformatf("mismatch at %0t: pc %h exception expected %b got %b",
                                    $time, TBL_PC[i], exp_fault, resp_exception));
            assert (resp_exception_plus2 === exp_plus2)
            else fail_run($sformatf("mismatch at %0t: pc %h plus2 expected %b got %b",
                                    $time, TBL_PC[i], exp_plus2, resp_exception_plus2));
            if (!exp_fault) begin
                assert (resp_instr === exp_instr)
                else fail_run($sformatf("mismatch at %0t: pc %h instr expected %h got %h",
                                        $time, TBL_PC[i], exp_instr, resp_instr));
            end
        end

        @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the rvc_fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"
PASS_MSG="Simulation finished: PASS"

verilator --binary --timing --assert \
    --top-module fetch_top_tb \
    --Mdir obj_dir -o fetch_sim \
    -f rvc_fetch.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Test failed"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulator returned status $sim_status"
    exit 1
fi

if ! grep -q "$PASS_MSG" "$LOG"; then
    echo "No pass message in $LOG"
    exit 1
fi

exit 0

/* rvc_fetch.f */
src/fetch_pkg.sv
src/icache_if.sv
src/fetch_align.sv
src/word_icache.sv
src/fetch_top.sv
dv/fetch_clk_gen.sv
dv/fetch_top_tb.sv

/* src/fetch_align.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Aligner for halfword-aligned fetches over a word store
// Kept halves are reused only on IF_PREFETCH fetches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_align (
    input logic        clk,
    input logic        rstn,
    icache_if.provider cache,
    icache_if.user     mem
);

    import fetch_pkg::*;

    // Incoming bus fields pulled into plain signals
    logic            cpu_req_valid;
    logic [XLEN-1:0] cpu_req_pc;
    if_reason_e      cpu_req_reason;
    logic            mem_resp_valid;
    logic [31:0]     mem_resp_instr;
    logic            mem_resp_exception;

    // Outgoing bus fields built by the combinational block
    logic            mem_req_valid;
    logic [XLEN-1:0] mem_req_pc;
    if_reason_e      mem_req_reason;
    logic            cpu_resp_valid;
    logic [31:0]     cpu_resp_instr;
    logic            cpu_resp_exception;
    logic            cpu_resp_plus2;

    // The current fetch started at a pc with bit 1 set
    logic misaligned, misaligned_d;

    // The word in flight holds the first half of a misaligned fetch
    logic fetch_first_half, fetch_first_half_d;

    // Upper halfword of the last word read that no response has used yet
    logic [15:0] prev_instr, prev_instr_d;
    logic        prev_valid, prev_valid_d;

    // Address of the word after the last one read, ready before it is needed
    logic [XLEN-1:0] next_pc, next_pc_d;

    // Length bits of the two halves of the returned word
    logic lo_is_32;
    logic hi_is_32;

    // The kept halfword starts a 32-bit instruction that a prefetch can finish
    logic use_kept;

    assign cpu_req_valid      = cache.req_valid;
    assign cpu_req_pc         = cache.req_pc;
    assign cpu_req_reason     = cache.req_reason;
    assign mem_resp_valid     = mem.resp_valid;
    assign mem_resp_instr     = mem.resp_instr;
    assign mem_resp_exception = mem.resp_exception;

    assign lo_is_32 = mem_resp_instr[1:0] == 2'b11;
    assign hi_is_32 = mem_resp_instr[17:16] == 2'b11;

    always_comb begin
        mem_req_valid      = 1'b0;
        mem_req_pc         = '0;
        mem_req_reason     = IF_PREFETCH;
        cpu_resp_valid     = 1'b0;
        cpu_resp_instr     = '0;
        cpu_resp_exception = 1'b0;
        cpu_resp_plus2     = 1'b0;

        misaligned_d       = misaligned;
        fetch_first_half_d = fetch_first_half;
        prev_instr_d       = prev_instr;
        prev_valid_d       = prev_valid;
        next_pc_d          = next_pc;

        // Response assembly
        if (mem_resp_valid) begin
            // Whatever was kept is used or replaced by this word
            prev_valid_d = 1'b0;

            if (mem_resp_exception) begin
                // A fault on the second word of a split fetch points 2 bytes further
                cpu_resp_valid     = 1'b1;
                cpu_resp_exception = 1'b1;
                cpu_resp_plus2     = misaligned && !fetch_first_half;
            end else if (fetch_first_half && hi_is_32) begin
                // Only the low half of a 32-bit instruction arrived
                // Keep it and read the next word right away
                prev_instr_d       = mem_resp_instr[31:16];
                prev_valid_d       = 1'b1;
                mem_req_valid      = 1'b1;
                mem_req_pc         = next_pc;
                mem_req_reason     = IF_PREFETCH;
                next_pc_d          = next_pc + XLEN'(4);
                fetch_first_half_d = 1'b0;
            end else begin
                cpu_resp_valid = 1'b1;
                if (!misaligned) begin
                    if (lo_is_32) begin
                        // Whole aligned 32-bit instruction
                        cpu_resp_instr = mem_resp_instr;
                    end else begin
                        // Aligned compressed instruction, the upper half may follow it
                        cpu_resp_instr = {16'h0000, mem_resp_instr[15:0]};
                        prev_instr_d   = mem_resp_instr[31:16];
                        prev_valid_d   = 1'b1;
                    end
                end else if (fetch_first_half) begin
                    // Misaligned start with a compressed instruction in the upper half
                    cpu_resp_instr = {16'h0000, mem_resp_instr[31:16]};
                end else begin
                    // Second word of a split instruction joined to the kept low half
                    cpu_resp_instr = {mem_resp_instr[15:0], prev_instr};
                    prev_instr_d   = mem_resp_instr[31:16];
                    prev_valid_d   = 1'b1;
                end
            end
        end

        // Request steering sees the kept half as updated by a response this cycle
        use_kept = prev_valid_d && cpu_req_reason == IF_PREFETCH && prev_instr_d[1:0] == 2'b11;

        if (cpu_req_valid) begin
            mem_req_valid      = 1'b1;
            mem_req_pc         = cpu_req_pc;
            mem_req_reason     = cpu_req_reason;
            misaligned_d       = cpu_req_pc[1];
            next_pc_d          = {cpu_req_pc[XLEN-1:2], 2'b00} + XLEN'(4);
            fetch_first_half_d = cpu_req_pc[1];

            // The low half is already here so the first read is the next word
            // A kept compressed half is simply fetched again
            if (use_kept) begin
                mem_req_pc         = next_pc;
                mem_req_reason     = IF_PREFETCH;
                next_pc_d          = next_pc + XLEN'(4);
                fetch_first_half_d = 1'b0;
            end
        end
    end

    assign mem.req_valid              = mem_req_valid;
    assign mem.req_pc                 = mem_req_pc;
    assign mem.req_reason             = mem_req_reason;
    assign cache.resp_valid           = cpu_resp_valid;
    assign cache.resp_instr           = cpu_resp_instr;
    assign cache.resp_exception       = cpu_resp_exception;
    assign cache.resp_exception_plus2 = cpu_resp_plus2;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            misaligned       <= 1'b0;
            fetch_first_half <= 1'b0;
            prev_valid       <= 1'b0;
        end else begin
            misaligned       <= misaligned_d;
            fetch_first_half <= fetch_first_half_d;
            prev_valid       <= prev_valid_d;
        end
    end

    // The kept half and next word address are only read under their flags
    always_ff @(posedge clk) begin
        prev_instr <= prev_instr_d;
        next_pc    <= next_pc_d;
    end

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, store depth and fetch reasons for rvc_fetch
// The store depth must stay a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fetch_pkg;

    // Width of the program counter
    localparam int XLEN = 32;

    // Depth of the instruction store in 32-bit words
    localparam int ICACHE_WORDS = 64;

    // Width of the word index into the store
    localparam int ICACHE_IDX_BITS = $clog2(ICACHE_WORDS);

    // Why a fetch was issued
    // IF_PREFETCH means the pc directly follows the previous fetch, so any halfword
    // kept from the last word read may be reused
    // IF_PREDICT and IF_MISPREDICT both mark a jump in the instruction stream
    // The aligner treats them the same way and the store ignores the reason
    typedef enum logic [1:0] {
        IF_PREFETCH   = 2'b00,
        IF_PREDICT    = 2'b01,
        IF_MISPREDICT = 2'b10
    } if_reason_e;

endpackage

`default_nettype wire

/* src/fetch_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch path top level with plain ports
// Load the store before the first fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 load_valid,
    input  logic [fetch_pkg::ICACHE_IDX_BITS-1:0] load_addr,
    input  logic [31:0]                          load_data,
    input  logic                                 req_valid,
    input  logic [fetch_pkg::XLEN-1:0]           req_pc,
    input  fetch_pkg::if_reason_e                req_reason,
    output logic                                 resp_valid,
    output logic [31:0]                          resp_instr,
    output logic                                 resp_exception,
    output logic                                 resp_exception_plus2
);

    // Client side, between the ports and the aligner
    icache_if cpu_bus ();

    // Word side, between the aligner and the store
    icache_if mem_bus ();

    assign cpu_bus.req_valid  = req_valid;
    assign cpu_bus.req_pc     = req_pc;
    assign cpu_bus.req_reason = req_reason;

    assign resp_valid           = cpu_bus.resp_valid;
    assign resp_instr           = cpu_bus.resp_instr;
    assign resp_exception       = cpu_bus.resp_exception;
    assign resp_exception_plus2 = cpu_bus.resp_exception_plus2;

    // Splits halfword fetches into word reads
    fetch_align align_i (
        .clk   (clk),
        .rstn  (rstn),
        .cache (cpu_bus),
        .mem   (mem_bus)
    );

    // Word array behind the aligner
    word_icache icache_i (
        .clk        (clk),
        .rstn       (rstn),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .bus        (mem_bus)
    );

endmodule

`default_nettype wire

/* src/icache_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe-only fetch bus with no back-pressure
// One fetch may be outstanding at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface icache_if;

    import fetch_pkg::*;

    // Request side, a one-cycle strobe with its pc and reason
    logic            req_valid;
    logic [XLEN-1:0] req_pc;
    if_reason_e      req_reason;

    // Response side, a one-cycle strobe with the instruction or a fault
    logic            resp_valid;
    logic [31:0]     resp_instr;
    logic            resp_exception;

    // Set with resp_exception when the fault hit the second word of a split fetch
    logic            resp_exception_plus2;

    // The block that answers fetches
    modport provider (
        input  req_valid,
        input  req_pc,
        input  req_reason,
        output resp_valid,
        output resp_instr,
        output resp_exception,
        output resp_exception_plus2
    );

    // The block that issues fetches
    modport user (
        output req_valid,
        output req_pc,
        output req_reason,
        input  resp_valid,
        input  resp_instr,
        input  resp_exception,
        input  resp_exception_plus2
    );

endinterface

`default_nettype wire

/* src/word_icache.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word store with one cycle of read latency
// pc bits 1:0 are ignored and the contents are not reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module word_icache (
    input logic                                 clk,
    input logic                                 rstn,
    input logic                                 load_valid,
    input logic [fetch_pkg::ICACHE_IDX_BITS-1:0] load_addr,
    input logic [31:0]                          load_data,
    icache_if.provider                          bus
);

    import fetch_pkg::*;

    // Instruction words, filled through the load port
    logic [31:0] mem_words [ICACHE_WORDS];

    // Word index taken from the request pc
    logic [ICACHE_IDX_BITS-1:0] req_idx;

    // Any pc bit above the index range points past the store
    logic req_out_of_range;

    // Registered response
    logic        resp_valid_q;
    logic [31:0] resp_instr_q;
    logic        resp_exception_q;

    assign req_idx          = bus.req_pc[ICACHE_IDX_BITS+1:2];
    assign req_out_of_range = |bus.req_pc[XLEN-1:ICACHE_IDX_BITS+2];

    // Load port writes one word per strobe
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem_words[load_addr] <= load_data;
        end
    end

    // A request returns its word or its fault in the next cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= bus.req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req_valid) begin
            resp_exception_q <= req_out_of_range;
            // Out-of-range reads return zero so the data bus stays clean
            if (req_out_of_range) begin
                resp_instr_q <= '0;
            end else begin
                resp_instr_q <= mem_words[req_idx];
            end
        end
    end

    assign bus.resp_valid     = resp_valid_q;
    assign bus.resp_instr     = resp_instr_q;
    assign bus.resp_exception = resp_exception_q;

    // Whole words only, so a fault never sits 2 bytes in
    assign bus.resp_exception_plus2 = 1'b0;

endmodule

`default_nettype wire
